/* source/pito_csr_pkg.sv */
package pito_csr_pkg;

    localparam int NUM_HARTS      = 8;
    localparam int HART_CNT_WIDTH = 3;
    localparam int WORD_WIDTH     = 32;
    localparam int CSR_ADDR_WIDTH = 12;

    typedef logic [HART_CNT_WIDTH-1:0] hart_id_t;
    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [CSR_ADDR_WIDTH-1:0] csr_addr_t;

    // Machine mode CSR addresses
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    localparam csr_addr_t CSR_MCYCLE   = 12'hB00;
    localparam csr_addr_t CSR_MHARTID  = 12'hF14;

    localparam word_t ILLEGAL_INSTR_CAUSE = 32'd2;

    localparam int MSTATUS_MIE_BIT = 3;
    localparam int MIP_MSIP_BIT    = 3;     // Inter processor
    localparam int MIP_MTIP_BIT    = 7;     // Timer
    localparam int MIP_MEIP_BIT    = 11;    // External
    localparam int MIP_MVU_BIT     = 16;    // Accelerator, platform range

    typedef enum logic [2:0] {
        CSR_NONE = 3'd0,
        CSR_R    = 3'd1,
        CSR_RW   = 3'd2,
        CSR_RS   = 3'd3,
        CSR_RC   = 3'd4
    } csr_op_e;

    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_MSTATUS,
        SEL_MIE,
        SEL_MIP,
        SEL_MTVEC,
        SEL_MEPC,
        SEL_MCAUSE,
        SEL_MSCRATCH,
        SEL_MCYCLE,
        SEL_MHARTID
    } csr_sel_e;

    typedef struct packed {
        hart_id_t  hart;     // Target hart
        csr_addr_t addr;     // Raw address, used as tval
        csr_sel_e  sel;
        csr_op_e   op;
        word_t     wdata;
        logic      write;    // RW, RS or RC
        logic      legal;
    } csr_req_t;

    typedef struct packed {
        logic  valid;
        word_t cause;
        word_t tval;
    } exception_t;

    typedef struct packed {
        logic       valid;
        word_t      rdata;
        exception_t exc;
        word_t      epc;
    } csr_rsp_t;

endpackage

/* source/rv32_csr_decode.sv */
`timescale 1ns/1ps

module rv32_csr_decode
    import pito_csr_pkg::*;
(
    input  csr_addr_t csr_addr_i,
    input  csr_op_e   csr_op_i,
    input  word_t     csr_wdata_i,
    input  hart_id_t  hart_id_i,
    output csr_req_t  req_o
);

    csr_sel_e sel;
    logic     is_write;
    logic     read_only;
    logic     req_present;

    // Address to register select
    always_comb begin
        case (csr_addr_i)
            CSR_MSTATUS:  sel = SEL_MSTATUS;
            CSR_MIE:      sel = SEL_MIE;
            CSR_MIP:      sel = SEL_MIP;
            CSR_MTVEC:    sel = SEL_MTVEC;
            CSR_MEPC:     sel = SEL_MEPC;
            CSR_MCAUSE:   sel = SEL_MCAUSE;
            CSR_MSCRATCH: sel = SEL_MSCRATCH;
            CSR_MCYCLE:   sel = SEL_MCYCLE;
            CSR_MHARTID:  sel = SEL_MHARTID;
            default:      sel = SEL_NONE;       // Unknown address
        endcase
    end

    always_comb begin
        case (csr_op_i)
            CSR_RW,
            CSR_RS,
            CSR_RC:  is_write = 1'b1;
            default: is_write = 1'b0;
        endcase
    end

    assign req_present = (csr_op_i != CSR_NONE);
    assign read_only   = (sel == SEL_MHARTID) || (sel == SEL_MIP);

    // Hart match is left to each CSR file
    always_comb begin
        req_o.hart  = hart_id_i;
        req_o.addr  = csr_addr_i;
        req_o.sel   = sel;
        req_o.op    = csr_op_i;
        req_o.wdata = csr_wdata_i;
        req_o.write = is_write;
        req_o.legal = req_present && (sel != SEL_NONE) && !(is_write && read_only);
    end

endmodule

/* source/rv32_csr.sv */
`timescale 1ns/1ps

module rv32_csr
    import pito_csr_pkg::*;
#(
    parameter int HART_ID = 0
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  csr_req_t req_i,
    input  logic     trap_i,
    input  word_t    pc_i,
    input  word_t    cause_i,
    input  logic     ext_irq_i,
    input  logic     time_irq_i,
    input  logic     ipi_i,
    input  logic     mvu_irq_i,
    input  word_t    boot_addr_i,
    output word_t    rdata_o,
    output word_t    epc_o,
    output logic     irq_pending_o
);

    logic  hart_sel;
    logic  csr_we;
    logic  trap_en;
    word_t wr_val;

    logic  mstatus_mie_q;
    word_t mie_q;
    word_t mtvec_q;
    word_t mepc_q;
    word_t mcause_q;
    word_t mscratch_q;
    word_t mcycle_q;
    logic  meip_q;
    logic  mtip_q;
    logic  msip_q;
    logic  mvip_q;
    logic  irq_pending_q;

    word_t mstatus_val;
    word_t mip_val;

    function automatic word_t apply_op(csr_op_e op, word_t old_val, word_t wdata);
        word_t res;
        case (op)
            CSR_RW:  res = wdata;
            CSR_RS:  res = old_val | wdata;
            CSR_RC:  res = old_val & ~wdata;
            default: res = old_val;
        endcase
        return res;
    endfunction

    assign hart_sel = (req_i.hart == hart_id_t'(HART_ID));
    assign csr_we   = hart_sel && req_i.legal && req_i.write;
    assign trap_en  = hart_sel && trap_i;
    assign wr_val   = apply_op(req_i.op, rdata_o, req_i.wdata);   // Old value is the read value

    always_comb begin
        mstatus_val                  = '0;
        mstatus_val[MSTATUS_MIE_BIT] = mstatus_mie_q;
        mip_val                      = '0;
        mip_val[MIP_MSIP_BIT]        = msip_q;
        mip_val[MIP_MTIP_BIT]        = mtip_q;
        mip_val[MIP_MEIP_BIT]        = meip_q;
        mip_val[MIP_MVU_BIT]         = mvip_q;
    end

    always_comb begin
        case (req_i.sel)
            SEL_MSTATUS:  rdata_o = mstatus_val;
            SEL_MIE:      rdata_o = mie_q;
            SEL_MIP:      rdata_o = mip_val;
            SEL_MTVEC:    rdata_o = mtvec_q;
            SEL_MEPC:     rdata_o = mepc_q;
            SEL_MCAUSE:   rdata_o = mcause_q;
            SEL_MSCRATCH: rdata_o = mscratch_q;
            SEL_MCYCLE:   rdata_o = mcycle_q;
            SEL_MHARTID:  rdata_o = word_t'(HART_ID);
            default:      rdata_o = '0;
        endcase
    end

    // Plain read-write registers
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mstatus_mie_q <= 1'b0;
            mie_q         <= '0;
            mtvec_q       <= boot_addr_i;       // Boot vector
            mscratch_q    <= '0;
        end else if (csr_we) begin
            case (req_i.sel)
                SEL_MSTATUS:  mstatus_mie_q <= wr_val[MSTATUS_MIE_BIT];
                SEL_MIE:      mie_q         <= wr_val;
                SEL_MTVEC:    mtvec_q       <= wr_val;
                SEL_MSCRATCH: mscratch_q    <= wr_val;
                default:      ;
            endcase
        end
    end

    // Trap capture has priority over a CSR write
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mepc_q   <= '0;
            mcause_q <= '0;
        end else if (trap_en) begin
            mepc_q   <= pc_i;
            mcause_q <= cause_i;
        end else if (csr_we) begin
            if (req_i.sel == SEL_MEPC)   mepc_q   <= wr_val;
            if (req_i.sel == SEL_MCAUSE) mcause_q <= wr_val;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mcycle_q <= '0;
        end else if (csr_we && (req_i.sel == SEL_MCYCLE)) begin
            mcycle_q <= wr_val;
        end else begin
            mcycle_q <= mcycle_q + 32'd1;
        end
    end

    // Shared lines only land on the selected hart
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            meip_q <= 1'b0;
            mtip_q <= 1'b0;
            msip_q <= 1'b0;
            mvip_q <= 1'b0;
        end else begin
            if (hart_sel) begin
                meip_q <= ext_irq_i;
                mtip_q <= time_irq_i;
                msip_q <= ipi_i;
            end
            mvip_q <= mvu_irq_i;                // Own line, every cycle
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            irq_pending_q <= 1'b0;
        end else begin
            irq_pending_q <= mstatus_mie_q && |(mip_val & mie_q);
        end
    end

    assign epc_o         = mepc_q;
    assign irq_pending_o = irq_pending_q;

endmodule

/* source/rv32_csr_resp.sv */
`timescale 1ns/1ps

module rv32_csr_resp
    import pito_csr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  csr_req_t req_i,
    input  word_t    rdata_i [NUM_HARTS],
    input  word_t    epc_i   [NUM_HARTS],
    output csr_rsp_t rsp_o
);

    logic     req_valid;
    logic     exc_valid;
    csr_rsp_t rsp_d;
    csr_rsp_t rsp_q;

    assign req_valid = (req_i.op != CSR_NONE);
    assign exc_valid = req_valid && !req_i.legal;

    always_comb begin
        rsp_d.valid     = req_valid;
        rsp_d.rdata     = req_i.legal ? rdata_i[req_i.hart] : '0;   // Zero on illegal
        rsp_d.exc.valid = exc_valid;
        rsp_d.exc.cause = exc_valid ? ILLEGAL_INSTR_CAUSE : '0;
        rsp_d.exc.tval  = exc_valid ? word_t'(req_i.addr) : '0;
        rsp_d.epc       = epc_i[req_i.hart];
    end

    // One cycle response latency
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsp_q.valid     <= 1'b0;
            rsp_q.exc.valid <= 1'b0;
        end else begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_o = rsp_q;

endmodule

/* source/rv32_barrel_csrfiles.sv */
`timescale 1ns/1ps

module rv32_barrel_csrfiles
    import pito_csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  csr_addr_t            csr_addr_i,     // CSR address
    input  csr_op_e              csr_op_i,       // CSR_NONE when idle
    input  word_t                csr_wdata_i,
    input  hart_id_t             hart_id_i,      // Hart issuing this cycle
    input  logic                 trap_i,
    input  word_t                pc_i,           // PC of the trapping instruction
    input  word_t                cause_i,
    input  logic                 ext_irq_i,
    input  logic                 time_irq_i,
    input  logic                 ipi_i,
    input  logic [NUM_HARTS-1:0] mvu_irq_i,      // One per hart
    input  word_t                boot_addr_i,
    output csr_rsp_t             rsp_o,
    output logic [NUM_HARTS-1:0] irq_pending_o
);

    csr_req_t             req;
    word_t                rdata    [NUM_HARTS];
    word_t                epc      [NUM_HARTS];
    logic [NUM_HARTS-1:0] ext_irq;
    logic [NUM_HARTS-1:0] time_irq;
    logic [NUM_HARTS-1:0] ipi;

    rv32_csr_decode i_decode (
        .csr_addr_i  (csr_addr_i),
        .csr_op_i    (csr_op_i),
        .csr_wdata_i (csr_wdata_i),
        .hart_id_i   (hart_id_i),
        .req_o       (req)
    );

    for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
        // Shared lines reach the issuing hart only
        assign ext_irq[h]  = (hart_id_i == hart_id_t'(h)) ? ext_irq_i  : 1'b0;
        assign time_irq[h] = (hart_id_i == hart_id_t'(h)) ? time_irq_i : 1'b0;
        assign ipi[h]      = (hart_id_i == hart_id_t'(h)) ? ipi_i      : 1'b0;

        rv32_csr #(
            .HART_ID (h)
        ) i_csr (
            .clk           (clk),
            .rst_n_i       (rst_n_i),
            .req_i         (req),
            .trap_i        (trap_i),
            .pc_i          (pc_i),
            .cause_i       (cause_i),
            .ext_irq_i     (ext_irq[h]),
            .time_irq_i    (time_irq[h]),
            .ipi_i         (ipi[h]),
            .mvu_irq_i     (mvu_irq_i[h]),
            .boot_addr_i   (boot_addr_i),
            .rdata_o       (rdata[h]),
            .epc_o         (epc[h]),
            .irq_pending_o (irq_pending_o[h])
        );
    end

    rv32_csr_resp i_resp (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (req),
        .rdata_i (rdata),
        .epc_i   (epc),
        .rsp_o   (rsp_o)
    );

endmodule

/* dv/rv32_barrel_csrfiles_asserts.sv */
`timescale 1ns/1ps

module rv32_barrel_csrfiles_asserts
    import pito_csr_pkg::*;
(
    input logic                 clk,
    input logic                 rst_n_i,
    input csr_op_e              csr_op_i,
    input csr_rsp_t             rsp_o,
    input logic [NUM_HARTS-1:0] irq_pending_o
);

    // One cycle response latency
    property p_valid_after_op;
        @(posedge clk) disable iff (!rst_n_i)
        (csr_op_i != CSR_NONE) |=> rsp_o.valid;
    endproperty

    property p_no_valid_after_idle;
        @(posedge clk) disable iff (!rst_n_i)
        (csr_op_i == CSR_NONE) |=> !rsp_o.valid;
    endproperty

    property p_exc_needs_valid;
        @(posedge clk) disable iff (!rst_n_i)
        rsp_o.exc.valid |-> rsp_o.valid;
    endproperty

    // First cycle out of reset
    property p_quiet_after_reset;
        @(posedge clk)
        $rose(rst_n_i) |-> (!rsp_o.valid && (irq_pending_o == '0));
    endproperty

    a_valid_after_op:      assert property (p_valid_after_op)
        else $error("Response valid missing one cycle after a request");
    a_no_valid_after_idle: assert property (p_no_valid_after_idle)
        else $error("Response valid seen without a request");
    a_exc_needs_valid:     assert property (p_exc_needs_valid)
        else $error("Exception valid without response valid");
    a_quiet_after_reset:   assert property (p_quiet_after_reset)
        else $error("Response or pending interrupt active right after reset");

endmodule

bind rv32_barrel_csrfiles rv32_barrel_csrfiles_asserts i_asserts (.*);

/* dv/tb_rv32_barrel_csrfiles.sv */
`timescale 1ns/1ps

module tb_rv32_barrel_csrfiles
    import pito_csr_pkg::*;
();

    localparam int    N_RAND      = 300;
    localparam int    STIM_CYCLES = 3 + 9*NUM_HARTS + N_RAND + 2*NUM_HARTS + 60;
    localparam int    MAX_CYCLES  = 2*STIM_CYCLES + 100;
    localparam word_t BOOT_ADDR   = 32'h8000_0100;
    localparam word_t IRQ_MASK    = 32'h0001_0888;     // MSIP, MTIP, MEIP and MVU

    typedef struct packed {
        csr_op_e   op;
        csr_addr_t addr;
        word_t     wdata;
        hart_id_t  hart;
        logic      trap;
        word_t     pc;
        word_t     cause;
        logic      ext;
        logic      tim;
        logic      ipi;
    } stim_t;

    logic                 clk;
    logic                 rst_n_i;
    csr_addr_t            csr_addr_i;
    csr_op_e              csr_op_i;
    word_t                csr_wdata_i;
    hart_id_t             hart_id_i;
    logic                 trap_i;
    word_t                pc_i;
    word_t                cause_i;
    logic                 ext_irq_i;
    logic                 time_irq_i;
    logic                 ipi_i;
    logic [NUM_HARTS-1:0] mvu_irq_i;
    word_t                boot_addr_i;
    csr_rsp_t             rsp_o;
    logic [NUM_HARTS-1:0] irq_pending_o;

    // Shadow of every hart, mcycle left out
    logic  sh_mie_bit  [NUM_HARTS];
    word_t sh_mie      [NUM_HARTS];
    word_t sh_mtvec    [NUM_HARTS];
    word_t sh_mepc     [NUM_HARTS];
    word_t sh_mcause   [NUM_HARTS];
    word_t sh_mscratch [NUM_HARTS];
    word_t sh_mip      [NUM_HARTS];

    csr_rsp_t             nxt_rsp;
    csr_rsp_t             chk_rsp;
    logic [NUM_HARTS-1:0] nxt_irq;
    logic [NUM_HARTS-1:0] chk_irq;
    logic                 nxt_en;
    logic                 chk_en;
    logic                 nxt_cyc;
    logic                 chk_cyc;
    word_t                mcycle_log [$];
    int                   value_errs;
    int                   other_errs;
    int                   checks;
    int                   cycle_cnt;
    integer               seed;

    rv32_barrel_csrfiles i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, run stopped before all tests ended", cycle_cnt);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic csr_addr_t addr_of(int i);
        case (i)
            0:       return CSR_MSTATUS;
            1:       return CSR_MIE;
            2:       return CSR_MTVEC;
            3:       return CSR_MEPC;
            4:       return CSR_MCAUSE;
            5:       return CSR_MSCRATCH;
            6:       return CSR_MIP;
            7:       return CSR_MHARTID;
            default: return CSR_MCYCLE;
        endcase
    endfunction

    function automatic logic [NUM_HARTS-1:0] ref_irq();
        logic [NUM_HARTS-1:0] p;
        for (int h = 0; h < NUM_HARTS; h++) begin
            p[h] = sh_mie_bit[h] && |(sh_mip[h] & sh_mie[h]);
        end
        return p;
    endfunction

    // Expected response, then shadow update for the same cycle
    function automatic csr_rsp_t ref_access(stim_t s, logic [NUM_HARTS-1:0] mvu);
        csr_rsp_t r;
        word_t    old;
        word_t    upd;
        logic     known;
        logic     wr;
        logic     legal;
        known = 1'b1;
        case (s.addr)
            CSR_MSTATUS:  old = word_t'(sh_mie_bit[s.hart]) << MSTATUS_MIE_BIT;
            CSR_MIE:      old = sh_mie[s.hart];
            CSR_MTVEC:    old = sh_mtvec[s.hart];
            CSR_MEPC:     old = sh_mepc[s.hart];
            CSR_MCAUSE:   old = sh_mcause[s.hart];
            CSR_MSCRATCH: old = sh_mscratch[s.hart];
            CSR_MIP:      old = sh_mip[s.hart];
            CSR_MCYCLE:   old = '0;                 // Checked by difference
            CSR_MHARTID:  old = word_t'(s.hart);
            default: begin
                old   = '0;
                known = 1'b0;
            end
        endcase
        wr    = (s.op == CSR_RW) || (s.op == CSR_RS) || (s.op == CSR_RC);
        legal = (s.op != CSR_NONE) && known &&
                !(wr && ((s.addr == CSR_MHARTID) || (s.addr == CSR_MIP)));
        case (s.op)
            CSR_RW:  upd = s.wdata;
            CSR_RS:  upd = old | s.wdata;
            CSR_RC:  upd = old & ~s.wdata;
            default: upd = old;
        endcase
        r       = '0;
        r.valid = (s.op != CSR_NONE);
        r.epc   = sh_mepc[s.hart];
        if (legal) begin
            r.rdata = old;
        end else if (r.valid) begin
            r.exc.valid = 1'b1;
            r.exc.cause = ILLEGAL_INSTR_CAUSE;
            r.exc.tval  = word_t'(s.addr);
        end
        if (legal && wr) begin
            case (s.addr)
                CSR_MSTATUS:  sh_mie_bit[s.hart]  = upd[MSTATUS_MIE_BIT];
                CSR_MIE:      sh_mie[s.hart]      = upd;
                CSR_MTVEC:    sh_mtvec[s.hart]    = upd;
                CSR_MEPC:     sh_mepc[s.hart]     = upd;
                CSR_MCAUSE:   sh_mcause[s.hart]   = upd;
                CSR_MSCRATCH: sh_mscratch[s.hart] = upd;
                default:      ;
            endcase
        end
        if (s.trap) begin                           // Trap wins over the write
            sh_mepc[s.hart]   = s.pc;
            sh_mcause[s.hart] = s.cause;
        end
        sh_mip[s.hart][MIP_MEIP_BIT] = s.ext;
        sh_mip[s.hart][MIP_MTIP_BIT] = s.tim;
        sh_mip[s.hart][MIP_MSIP_BIT] = s.ipi;
        for (int h = 0; h < NUM_HARTS; h++) begin
            sh_mip[h][MIP_MVU_BIT] = mvu[h];
        end
        return r;
    endfunction

    task automatic check_word(string name, word_t exp, word_t act);
        checks++;
        if (exp !== act) begin
            value_errs++;
            $display("FAILED %s exp=%h act=%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_exc(string name, exception_t exp, exception_t act);
        checks++;
        if (exp !== act) begin
            value_errs++;
            $display("FAILED %s exp valid=%h cause=%h tval=%h act valid=%h cause=%h tval=%h",
                     name, exp.valid, exp.cause, exp.tval, act.valid, act.cause, act.tval);
        end
    endtask

    task automatic check_irq(logic [NUM_HARTS-1:0] exp, logic [NUM_HARTS-1:0] act);
        checks++;
        if (exp !== act) begin
            value_errs++;
            $display("FAILED irq_pending_o exp=%h act=%h at %0t", exp, act, $time);
        end
    endtask

    task automatic expect_true(logic cond, string what);
        checks++;
        if (cond !== 1'b1) begin
            other_errs++;
            $display("Check failed at %0t: %s", $time, what);
        end
    endtask

    // Called at posedge + 1 ns, returns one cycle later
    task automatic drive(stim_t s);
        csr_addr_i  = s.addr;
        csr_op_i    = s.op;
        csr_wdata_i = s.wdata;
        hart_id_i   = s.hart;
        trap_i      = s.trap;
        pc_i        = s.pc;
        cause_i     = s.cause;
        ext_irq_i   = s.ext;
        time_irq_i  = s.tim;
        ipi_i       = s.ipi;
        chk_rsp     = nxt_rsp;
        chk_irq     = nxt_irq;
        chk_en      = nxt_en;
        chk_cyc     = nxt_cyc;
        nxt_irq     = ref_irq();                    // From state before this edge
        nxt_rsp     = ref_access(s, mvu_irq_i);
        nxt_en      = 1'b1;
        nxt_cyc     = (s.op != CSR_NONE) && (s.addr == CSR_MCYCLE);
        @(posedge clk);
        #1;
    endtask

    function automatic stim_t make_req(hart_id_t h, csr_op_e op, csr_addr_t a, word_t d);
        stim_t s;
        s       = '0;
        s.hart  = h;
        s.op    = op;
        s.addr  = a;
        s.wdata = d;
        return s;
    endfunction

    task automatic access(hart_id_t h, csr_op_e op, csr_addr_t a, word_t d);
        drive(make_req(h, op, a, d));
    endtask

    task automatic idle(hart_id_t h);
        drive(make_req(h, CSR_NONE, '0, '0));
    endtask

    // Response of the request one cycle earlier
    always @(negedge clk) begin
        if (chk_en) begin
            check_word("rsp_o.valid", word_t'(chk_rsp.valid), word_t'(rsp_o.valid));
            if (chk_rsp.valid) begin
                if (chk_cyc) begin
                    mcycle_log.push_back(rsp_o.rdata);
                end else begin
                    check_word("rsp_o.rdata", chk_rsp.rdata, rsp_o.rdata);
                end
                check_exc("rsp_o.exc", chk_rsp.exc, rsp_o.exc);
                check_word("rsp_o.epc", chk_rsp.epc, rsp_o.epc);
            end
            check_irq(chk_irq, irq_pending_o);
        end
    end

    initial begin
        stim_t       s;
        int unsigned r;
        int          base;
        seed        = 32'h5825_00a5;
        value_errs  = 0;
        other_errs  = 0;
        checks      = 0;
        cycle_cnt   = 0;
        rst_n_i     = 1'b0;
        csr_addr_i  = '0;
        csr_op_i    = CSR_NONE;
        csr_wdata_i = '0;
        hart_id_i   = '0;
        trap_i      = 1'b0;
        pc_i        = '0;
        cause_i     = '0;
        ext_irq_i   = 1'b0;
        time_irq_i  = 1'b0;
        ipi_i       = 1'b0;
        mvu_irq_i   = '0;
        boot_addr_i = BOOT_ADDR;
        nxt_rsp     = '0;
        chk_rsp     = '0;
        nxt_irq     = '0;
        chk_irq     = '0;
        nxt_en      = 1'b0;
        chk_en      = 1'b0;
        nxt_cyc     = 1'b0;
        chk_cyc     = 1'b0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            sh_mie_bit[h]  = 1'b0;
            sh_mie[h]      = '0;
            sh_mtvec[h]    = BOOT_ADDR;
            sh_mepc[h]     = '0;
            sh_mcause[h]   = '0;
            sh_mscratch[h] = '0;
            sh_mip[h]      = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // Reset values of all nine registers on every hart
        for (int h = 0; h < NUM_HARTS; h++) begin
            for (int i = 0; i < 9; i++) begin
                access(hart_id_t'(h), CSR_R, addr_of(i), '0);
            end
        end

        // Random back to back traffic
        for (int n = 0; n < N_RAND; n++) begin
            s       = '0;
            s.hart  = hart_id_t'($random(seed));
            r       = $random(seed);
            case (r % 8)
                0:       s.op = CSR_NONE;
                1:       s.op = CSR_R;
                2, 3:    s.op = CSR_RW;
                4, 5:    s.op = CSR_RS;
                default: s.op = CSR_RC;
            endcase
            s.addr  = addr_of((r >> 3) % 8);        // No mcycle writes
            s.wdata = $random(seed);
            s.ext   = ((r >> 6) % 8) == 0;
            s.tim   = ((r >> 9) % 8) == 0;
            s.ipi   = ((r >> 12) % 8) == 0;
            s.trap  = ((r >> 15) % 32) == 0;
            s.pc    = $random(seed);
            s.cause = $random(seed);
            if (((r >> 20) % 16) == 0) begin
                mvu_irq_i = NUM_HARTS'($random(seed));
            end
            drive(s);
        end

        // Hart h read mcycle as request 9h+8 after reset release
        expect_true(mcycle_log.size() == NUM_HARTS,
                    "mcycle reads after reset were not all answered");
        for (int h = 0; h < NUM_HARTS && h < mcycle_log.size(); h++) begin
            check_word("rsp_o.rdata mcycle", word_t'(9*h + 8), mcycle_log[h]);
        end

        // Illegal accesses
        access(3'd1, CSR_R, 12'h123, '0);
        access(3'd2, CSR_RW, 12'h7C0, 32'hFFFF_FFFF);
        access(3'd4, CSR_RS, 12'hFFF, 32'h0000_00FF);
        for (int k = 2; k <= 4; k++) begin
            access(3'd6, csr_op_e'(k), CSR_MHARTID, 32'hFFFF_FFFF);
            access(3'd6, csr_op_e'(k), CSR_MIP, 32'hFFFF_FFFF);
        end
        access(3'd6, CSR_R, CSR_MHARTID, '0);
        access(3'd6, CSR_R, CSR_MIP, '0);

        // Trap on hart 5 together with an mepc write
        s       = make_req(3'd5, CSR_RW, CSR_MEPC, 32'h0000_1234);
        s.trap  = 1'b1;
        s.pc    = 32'h8000_0444;
        s.cause = 32'h8000_000B;
        drive(s);
        for (int h = 0; h < NUM_HARTS; h++) begin
            access(hart_id_t'(h), CSR_R, CSR_MEPC, '0);
            access(hart_id_t'(h), CSR_R, CSR_MCAUSE, '0);
        end

        // Interrupt pending on hart 3
        mvu_irq_i = '0;
        access(3'd3, CSR_RW, CSR_MIE, IRQ_MASK);
        access(3'd3, CSR_RW, CSR_MSTATUS, 32'h0000_0008);
        idle(3'd3);
        idle(3'd3);
        for (int src = 0; src < 3; src++) begin
            s     = make_req(3'd3, CSR_NONE, '0, '0);
            s.ext = (src == 0);
            s.tim = (src == 1);
            s.ipi = (src == 2);
            drive(s);
            idle(3'd3);
            expect_true(irq_pending_o[3], "interrupt line did not raise pending in two cycles");
            idle(3'd3);
            idle(3'd3);
        end
        mvu_irq_i[3] = 1'b1;
        idle(3'd3);
        idle(3'd3);
        expect_true(irq_pending_o[3], "MVU line did not raise pending in two cycles");
        access(3'd3, CSR_RC, CSR_MSTATUS, 32'h0000_0008);
        idle(3'd3);
        expect_true(!irq_pending_o[3], "clearing mstatus MIE left pending set");
        mvu_irq_i = '0;
        idle(3'd3);

        // mcycle distance, reads 7 cycles apart
        base = mcycle_log.size();
        access(3'd2, CSR_R, CSR_MCYCLE, '0);
        repeat (6) idle(3'd2);
        access(3'd2, CSR_R, CSR_MCYCLE, '0);
        idle(3'd2);
        idle(3'd2);
        expect_true(mcycle_log.size() == base + 2, "mcycle reads were not both answered");
        if (mcycle_log.size() == base + 2) begin
            expect_true(mcycle_log[base+1] - mcycle_log[base] == 32'd7,
                        "mcycle did not advance by one per clock");
        end

        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
source/pito_csr_pkg.sv
source/rv32_csr_decode.sv
source/rv32_csr.sv
source/rv32_csr_resp.sv
source/rv32_barrel_csrfiles.sv
dv/rv32_barrel_csrfiles_asserts.sv
dv/tb_rv32_barrel_csrfiles.sv
